/* csr_pkg.sv */
package csr_pkg;

  localparam int rs_entries = 8;
  localparam int n_wake     = 4;

  localparam int tag_w      = 8;
  localparam int inst_num_w = 32;
  localparam int csr_addr_w = 12;
  localparam int xlen       = 32;
  localparam int zimm_w     = 5;
  localparam int rs_idx_w   = $clog2(rs_entries);

  typedef logic [tag_w-1:0]      tag_t;
  typedef logic [inst_num_w-1:0] inst_num_t;
  typedef logic [csr_addr_w-1:0] csr_addr_t;
  typedef logic [xlen-1:0]       xlen_t;
  typedef logic [zimm_w-1:0]     zimm_t;
  typedef logic [rs_idx_w-1:0]   rs_idx_t;

  typedef enum logic [1:0] {
    CSRRW = 2'd1,
    CSRRS = 2'd2,
    CSRRC = 2'd3
  } csr_op_t;

  // Machine CSR addresses
  localparam csr_addr_t csr_mstatus  = 12'h300;
  localparam csr_addr_t csr_mtvec    = 12'h305;
  localparam csr_addr_t csr_mscratch = 12'h340;
  localparam csr_addr_t csr_mepc     = 12'h341;
  localparam csr_addr_t csr_mcause   = 12'h342;

  localparam xlen_t mtvec_rst_val = 32'h0000_0100;

  // Implemented mstatus bits
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

endpackage

/* csr_issue_if.sv */
`timescale 1ns/1ns

interface csr_issue_if;

  logic                valid;     // One-cycle strobe, never stalled
  csr_pkg::inst_num_t  inst_num;
  csr_pkg::tag_t       rd;
  csr_pkg::csr_op_t    op;
  csr_pkg::tag_t       src_tag;   // Also drives the PRF read port
  logic                use_imm;
  csr_pkg::zimm_t      zimm;
  csr_pkg::csr_addr_t  addr;

  modport station (
    output valid, inst_num, rd, op, src_tag, use_imm, zimm, addr
  );

  modport exec (
    input valid, inst_num, rd, op, src_tag, use_imm, zimm, addr
  );

endinterface

/* csr_file.sv */
`timescale 1ns/1ns

module csr_file (
  input  logic                clk,
  input  logic                arst_n,
  input  csr_pkg::csr_addr_t  addr,
  output csr_pkg::xlen_t      rdata,
  output logic                hit,
  input  logic                we,
  input  csr_pkg::xlen_t      wdata
);

  logic           mie_q;
  logic           mpie_q;
  csr_pkg::xlen_t mtvec_q;
  csr_pkg::xlen_t mscratch_q;
  csr_pkg::xlen_t mepc_q;
  csr_pkg::xlen_t mcause_q;

  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (addr)
      csr_pkg::csr_mstatus: begin
        rdata[csr_pkg::mstatus_mie]  = mie_q;
        rdata[csr_pkg::mstatus_mpie] = mpie_q;
      end
      csr_pkg::csr_mtvec:    rdata = mtvec_q;
      csr_pkg::csr_mscratch: rdata = mscratch_q;
      csr_pkg::csr_mepc:     rdata = mepc_q;
      csr_pkg::csr_mcause:   rdata = mcause_q;
      default:               hit = 1'b0; // Unimplemented address
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mtvec_q    <= csr_pkg::mtvec_rst_val;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (we) begin
      case (addr)
        csr_pkg::csr_mstatus: begin
          mie_q  <= wdata[csr_pkg::mstatus_mie];
          mpie_q <= wdata[csr_pkg::mstatus_mpie];
        end
        csr_pkg::csr_mtvec:    mtvec_q    <= wdata;
        csr_pkg::csr_mscratch: mscratch_q <= wdata;
        csr_pkg::csr_mepc:     mepc_q     <= {wdata[csr_pkg::xlen-1:2], 2'b00};
        csr_pkg::csr_mcause:   mcause_q   <= wdata;
        default: ;
      endcase
    end
  end

endmodule

/* csr_exec.sv */
`timescale 1ns/1ns

module csr_exec (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                flush,
  csr_issue_if.exec           iss,
  input  csr_pkg::xlen_t      prf_rdata,
  input  csr_pkg::xlen_t      csr_rdata,
  input  logic                csr_hit,
  output logic                csr_we,
  output csr_pkg::xlen_t      csr_wdata,
  output csr_pkg::csr_addr_t  csr_addr,
  output logic                res_valid,
  output csr_pkg::inst_num_t  res_inst_num,
  output csr_pkg::tag_t       res_rd,
  output csr_pkg::xlen_t      res_data,
  output logic                res_illegal
);

  logic               s1_valid;
  csr_pkg::inst_num_t s1_inst_num;
  csr_pkg::tag_t      s1_rd;
  csr_pkg::csr_op_t   s1_op;
  csr_pkg::xlen_t     s1_operand;
  csr_pkg::csr_addr_t s1_addr;

  // Stage one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= iss.valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    s1_inst_num <= iss.inst_num;
    s1_rd       <= iss.rd;
    s1_op       <= iss.op;
    s1_addr     <= iss.addr;
    s1_operand  <= iss.use_imm ? csr_pkg::xlen_t'(iss.zimm) : prf_rdata; // Zero-extended zimm
  end

  // Stage two, read-modify-write
  assign csr_addr = s1_addr;
  assign csr_we   = s1_valid && csr_hit && !flush; // Killed op must not write

  always_comb begin
    case (s1_op)
      csr_pkg::CSRRW: csr_wdata = s1_operand;
      csr_pkg::CSRRS: csr_wdata = csr_rdata | s1_operand;
      csr_pkg::CSRRC: csr_wdata = csr_rdata & ~s1_operand;
      default:        csr_wdata = csr_rdata;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= s1_valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    res_inst_num <= s1_inst_num;
    res_rd       <= s1_rd;
    res_data     <= csr_hit ? csr_rdata : '0; // Old value
    res_illegal  <= !csr_hit;
  end

endmodule

/* csr_rs.sv */
`timescale 1ns/1ns

module csr_rs (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                flush,
  input  logic                                disp_valid,
  input  logic                                disp_src_ready,
  input  logic                                disp_use_imm,
  input  csr_pkg::inst_num_t                  disp_inst_num,
  input  csr_pkg::tag_t                       disp_rd,
  input  csr_pkg::tag_t                       disp_src_tag,
  input  csr_pkg::csr_op_t                    disp_op,
  input  csr_pkg::zimm_t                      disp_zimm,
  input  csr_pkg::csr_addr_t                  disp_addr,
  input  logic [csr_pkg::n_wake:0]            wake_valid,
  input  csr_pkg::tag_t [csr_pkg::n_wake:0]   wake_tag,
  output logic                                full,
  csr_issue_if.station                        iss
);

  logic [csr_pkg::rs_entries-1:0] busy;
  logic [csr_pkg::rs_entries-1:0] rdy;
  logic [csr_pkg::rs_entries-1:0] iss_oh;
  csr_pkg::rs_idx_t               iss_idx;
  csr_pkg::rs_idx_t               alloc_idx;
  logic                           disp_take;
  logic                           disp_rdy;

  // Entry payload
  csr_pkg::inst_num_t inst_num_q [csr_pkg::rs_entries];
  csr_pkg::tag_t      rd_q       [csr_pkg::rs_entries];
  csr_pkg::tag_t      src_tag_q  [csr_pkg::rs_entries];
  csr_pkg::csr_op_t   op_q       [csr_pkg::rs_entries];
  logic               use_imm_q  [csr_pkg::rs_entries];
  csr_pkg::zimm_t     zimm_q     [csr_pkg::rs_entries];
  csr_pkg::csr_addr_t addr_q     [csr_pkg::rs_entries];

  // Any valid wakeup bus carrying this tag
  function automatic logic woken(input csr_pkg::tag_t t);
    logic hit;
    hit = 1'b0;
    for (int b = 0; b <= csr_pkg::n_wake; b++) begin
      hit |= wake_valid[b] && (wake_tag[b] == t);
    end
    return hit;
  endfunction

  assign full      = &busy;
  assign disp_take = disp_valid && !full;
  assign disp_rdy  = disp_src_ready || disp_use_imm || woken(disp_src_tag);

  // Lowest free index
  always_comb begin
    alloc_idx = '0;
    for (int i = csr_pkg::rs_entries - 1; i >= 0; i--) begin
      if (!busy[i]) alloc_idx = csr_pkg::rs_idx_t'(i);
    end
  end

  // Lowest ready index wins
  always_comb begin
    iss_oh  = '0;
    iss_idx = '0;
    for (int i = csr_pkg::rs_entries - 1; i >= 0; i--) begin
      if (rdy[i]) begin
        iss_oh    = '0;
        iss_oh[i] = 1'b1;
        iss_idx   = csr_pkg::rs_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
      rdy  <= '0;
    end else if (flush) begin
      busy <= '0;
      rdy  <= '0;
    end else begin
      for (int i = 0; i < csr_pkg::rs_entries; i++) begin
        if (iss_oh[i]) begin
          busy[i] <= 1'b0; // Freed at the issue edge
          rdy[i]  <= 1'b0;
        end else if (busy[i] && !rdy[i] && woken(src_tag_q[i])) begin
          rdy[i] <= 1'b1;
        end
      end
      if (disp_take) begin
        busy[alloc_idx] <= 1'b1;
        rdy[alloc_idx]  <= disp_rdy;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (disp_take) begin
      inst_num_q[alloc_idx] <= disp_inst_num;
      rd_q[alloc_idx]       <= disp_rd;
      src_tag_q[alloc_idx]  <= disp_src_tag;
      op_q[alloc_idx]       <= disp_op;
      use_imm_q[alloc_idx]  <= disp_use_imm;
      zimm_q[alloc_idx]     <= disp_zimm;
      addr_q[alloc_idx]     <= disp_addr;
    end
  end

  assign iss.valid    = |iss_oh;
  assign iss.inst_num = inst_num_q[iss_idx];
  assign iss.rd       = rd_q[iss_idx];
  assign iss.op       = op_q[iss_idx];
  assign iss.src_tag  = src_tag_q[iss_idx];
  assign iss.use_imm  = use_imm_q[iss_idx];
  assign iss.zimm     = zimm_q[iss_idx];
  assign iss.addr     = addr_q[iss_idx];

  // Dispatcher must honor full
  a_no_disp_full: assert property (@(posedge clk) disable iff (!arst_n)
    disp_valid |-> !full);

  // At most one entry leaves per edge
  a_one_issue: assert property (@(posedge clk) disable iff (!arst_n)
    !flush |=> $onehot0($past(busy) & ~busy));

  a_iss_busy: assert property (@(posedge clk) disable iff (!arst_n)
    iss.valid |-> busy[iss_idx]);

endmodule

/* csr_core.sv */
`timescale 1ns/1ns

module csr_core (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 flush,
  input  logic                                 disp_valid,
  input  csr_pkg::inst_num_t                   disp_inst_num,
  input  csr_pkg::tag_t                        disp_rd,
  input  csr_pkg::csr_op_t                     disp_op,
  input  csr_pkg::tag_t                        disp_src_tag,
  input  logic                                 disp_src_ready,
  input  logic                                 disp_use_imm,
  input  csr_pkg::zimm_t                       disp_zimm,
  input  csr_pkg::csr_addr_t                   disp_addr,
  output logic                                 full,
  input  logic [csr_pkg::n_wake-1:0]           wake_valid,
  input  csr_pkg::tag_t [csr_pkg::n_wake-1:0]  wake_tag,
  output csr_pkg::tag_t                        prf_raddr,
  input  csr_pkg::xlen_t                       prf_rdata,
  output logic                                 res_valid,
  output csr_pkg::inst_num_t                   res_inst_num,
  output csr_pkg::tag_t                        res_rd,
  output csr_pkg::xlen_t                       res_data,
  output logic                                 res_illegal
);

  logic [csr_pkg::n_wake:0]           all_wake_valid;
  csr_pkg::tag_t [csr_pkg::n_wake:0]  all_wake_tag;
  csr_pkg::xlen_t                     csr_rdata;
  csr_pkg::xlen_t                     csr_wdata;
  csr_pkg::csr_addr_t                 csr_addr;
  logic                               csr_hit;
  logic                               csr_we;

  csr_issue_if iss_bus ();

  // Own result is the top wakeup bus
  assign all_wake_valid = {res_valid, wake_valid};
  assign all_wake_tag   = {res_rd, wake_tag};
  assign prf_raddr      = iss_bus.src_tag;

  csr_rs u_rs (
    .clk, .arst_n, .flush,
    .disp_valid, .disp_src_ready, .disp_use_imm, .disp_inst_num,
    .disp_rd, .disp_src_tag, .disp_op, .disp_zimm, .disp_addr,
    .wake_valid (all_wake_valid),
    .wake_tag   (all_wake_tag),
    .full,
    .iss        (iss_bus)
  );

  csr_exec u_exec (
    .clk, .arst_n, .flush,
    .iss       (iss_bus),
    .prf_rdata,
    .csr_rdata, .csr_hit, .csr_we, .csr_wdata, .csr_addr,
    .res_valid, .res_inst_num, .res_rd, .res_data, .res_illegal
  );

  csr_file u_file (
    .clk, .arst_n,
    .addr  (csr_addr),
    .rdata (csr_rdata),
    .hit   (csr_hit),
    .we    (csr_we),
    .wdata (csr_wdata)
  );

endmodule

/* tb_csr_core.sv */
`timescale 1ns/1ns

module tb_csr_core;

  localparam int n_cyc = 96;

  localparam csr_pkg::csr_op_t   rw    = csr_pkg::CSRRW;
  localparam csr_pkg::csr_op_t   rs    = csr_pkg::CSRRS;
  localparam csr_pkg::csr_op_t   rc    = csr_pkg::CSRRC;
  localparam csr_pkg::csr_addr_t a_mst = csr_pkg::csr_mstatus;
  localparam csr_pkg::csr_addr_t a_mtv = csr_pkg::csr_mtvec;
  localparam csr_pkg::csr_addr_t a_msc = csr_pkg::csr_mscratch;
  localparam csr_pkg::csr_addr_t a_mep = csr_pkg::csr_mepc;
  localparam csr_pkg::csr_addr_t a_mca = csr_pkg::csr_mcause;

  // One row per cycle; inst 0 means no dispatch, exp_cyc 0 no result,
  // wbus -1 no wakeup, fx 2 skips full
  typedef struct {
    int                 cyc, inst, rd, src, srdy, imm, zimm, wbus, wtag, fl, exp_cyc, fx;
    csr_pkg::csr_op_t   op;
    csr_pkg::csr_addr_t addr;
  } step_t;

  logic                                clk;
  logic                                arst_n;
  logic                                flush;
  logic                                disp_valid;
  csr_pkg::inst_num_t                  disp_inst_num;
  csr_pkg::tag_t                       disp_rd;
  csr_pkg::csr_op_t                    disp_op;
  csr_pkg::tag_t                       disp_src_tag;
  logic                                disp_src_ready;
  logic                                disp_use_imm;
  csr_pkg::zimm_t                      disp_zimm;
  csr_pkg::csr_addr_t                  disp_addr;
  logic                                full;
  logic [csr_pkg::n_wake-1:0]          wake_valid;
  csr_pkg::tag_t [csr_pkg::n_wake-1:0] wake_tag;
  csr_pkg::tag_t                       prf_raddr;
  csr_pkg::xlen_t                      prf_rdata;
  logic                                res_valid;
  csr_pkg::inst_num_t                  res_inst_num;
  csr_pkg::tag_t                       res_rd;
  csr_pkg::xlen_t                      res_data;
  logic                                res_illegal;

  step_t          tbl[$];
  csr_pkg::xlen_t prf [256];
  csr_pkg::xlen_t csr_m [5]; // mstatus, mtvec, mscratch, mepc, mcause
  int             errors = 0;

  csr_core dut0 (.*);

  assign prf_rdata = prf[prf_raddr]; // Same-cycle read port

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int csr_slot(input csr_pkg::csr_addr_t a);
    case (a)
      csr_pkg::csr_mstatus:  return 0;
      csr_pkg::csr_mtvec:    return 1;
      csr_pkg::csr_mscratch: return 2;
      csr_pkg::csr_mepc:     return 3;
      csr_pkg::csr_mcause:   return 4;
      default:               return -1;
    endcase
  endfunction

  task check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task add_step(input int cyc, inst, input csr_pkg::csr_op_t op,
                input csr_pkg::csr_addr_t addr,
                input int src, srdy, imm, zimm, wbus, wtag, fl, exp_cyc, fx);
    step_t s;
    s = '{cyc, inst, inst + 'h80, src, srdy, imm, zimm, wbus, wtag, fl, exp_cyc, fx, op, addr};
    tbl.push_back(s);
  endtask

  task drive_cycle(input int c);
    logic [csr_pkg::n_wake-1:0] wv;
    wv = '0;
    disp_valid <= 1'b0;
    flush      <= 1'b0;
    foreach (tbl[k]) begin
      if (tbl[k].cyc == c) begin
        disp_valid     <= tbl[k].inst != 0;
        disp_inst_num  <= csr_pkg::inst_num_t'(tbl[k].inst);
        disp_rd        <= csr_pkg::tag_t'(tbl[k].rd);
        disp_op        <= tbl[k].op;
        disp_addr      <= tbl[k].addr;
        disp_src_tag   <= csr_pkg::tag_t'(tbl[k].src);
        disp_src_ready <= tbl[k].srdy != 0;
        disp_use_imm   <= tbl[k].imm != 0;
        disp_zimm      <= csr_pkg::zimm_t'(tbl[k].zimm);
        flush          <= tbl[k].fl != 0;
        if (tbl[k].wbus >= 0) begin
          wv[tbl[k].wbus] = 1'b1;
          wake_tag[tbl[k].wbus] <= csr_pkg::tag_t'(tbl[k].wtag);
        end
      end
    end
    wake_valid <= wv;
  endtask

  // Compares DUT state after edge e with the table and the CSR model
  task check_edge(input int e);
    int             idx;
    int             slot;
    step_t          s;
    csr_pkg::xlen_t opnd;
    csr_pkg::xlen_t old_v;
    csr_pkg::xlen_t new_v;
    idx = -1;
    foreach (tbl[k]) begin
      if (tbl[k].cyc == e && tbl[k].fx != 2) check("full", full, tbl[k].fx);
      if (tbl[k].exp_cyc > 0 && tbl[k].exp_cyc == e) idx = k;
      if (tbl[k].exp_cyc == e + 2) check("prf_raddr", prf_raddr, tbl[k].src); // Issue cycle
    end
    check("res_valid", res_valid, idx >= 0);
    if (idx >= 0) begin
      s     = tbl[idx];
      opnd  = (s.imm != 0) ? csr_pkg::xlen_t'(s.zimm) : prf[s.src];
      slot  = csr_slot(s.addr);
      old_v = (slot >= 0) ? csr_m[slot] : '0;
      case (s.op)
        rw:      new_v = opnd;
        rs:      new_v = old_v | opnd;
        default: new_v = old_v & ~opnd;
      endcase
      if (slot == 0) new_v &= 32'h0000_0088; // MIE and MPIE only
      if (slot == 3) new_v[1:0] = 2'b00;
      if (slot >= 0) csr_m[slot] = new_v;
      check("res_inst_num", res_inst_num, s.inst);
      check("res_rd", res_rd, s.rd);
      check("res_data", res_data, old_v);
      check("res_illegal", res_illegal, slot < 0);
    end
  endtask

  task build_table;
    // Reset values read back
    add_step( 1,  1, rs, a_mst, 0, 0, 1, 0, -1, 0, 0,  3, 0);
    add_step( 2,  2, rs, a_mtv, 0, 0, 1, 0, -1, 0, 0,  4, 2);
    add_step( 3,  3, rs, a_msc, 0, 0, 1, 0, -1, 0, 0,  5, 2);
    add_step( 4,  4, rs, a_mep, 0, 0, 1, 0, -1, 0, 0,  6, 2);
    add_step( 5,  5, rs, a_mca, 0, 0, 1, 0, -1, 0, 0,  7, 2);
    // Register and immediate forms
    add_step(10, 11, rw, a_msc, 'h21, 1, 0,    0, -1, 0, 0, 12, 2);
    add_step(11, 12, rs, a_mst,    0, 0, 1, 'h1f, -1, 0, 0, 13, 2);
    add_step(12, 13, rw, a_mep, 'h22, 1, 0,    0, -1, 0, 0, 14, 2);
    add_step(13, 14, rc, a_msc,    0, 0, 1, 'h0f, -1, 0, 0, 15, 2);
    add_step(14, 15, rs, a_mst, 'h23, 1, 0,    0, -1, 0, 0, 16, 2);
    add_step(15, 16, rw, a_mtv,    0, 0, 1, 'h11, -1, 0, 0, 17, 2);
    add_step(16, 17, rc, a_mtv, 'h24, 1, 0,    0, -1, 0, 0, 18, 2);
    add_step(17, 18, rw, a_mca, 'h25, 1, 0,    0, -1, 0, 0, 19, 2);
    add_step(18, 19, rs, a_mst, 0, 0, 1, 0, -1, 0, 0, 20, 2);
    add_step(19, 20, rs, a_mtv, 0, 0, 1, 0, -1, 0, 0, 21, 2);
    add_step(20, 21, rs, a_msc, 0, 0, 1, 0, -1, 0, 0, 22, 2);
    add_step(21, 22, rs, a_mep, 0, 0, 1, 0, -1, 0, 0, 23, 2);
    add_step(22, 23, rs, a_mca, 0, 0, 1, 0, -1, 0, 0, 24, 2);
    // Wakeups; 42 waits on the result tag of 40
    add_step(26, 40, rw, a_msc, 'h30, 0, 0, 0, -1,    0, 0, 32, 0);
    add_step(27, 41, rs, a_msc, 'h31, 0, 0, 0, -1,    0, 0, 30, 2);
    add_step(28,  0, rw, a_msc,    0, 0, 0, 0,  2, 'h31, 0,  0, 2);
    add_step(29, 42, rw, a_mep, 'ha8, 0, 0, 0, -1,    0, 0, 35, 2);
    add_step(30,  0, rw, a_msc,    0, 0, 0, 0,  0, 'h30, 0,  0, 2);
    add_step(31, 43, rc, a_mca, 'h33, 0, 0, 0,  3, 'h33, 0, 33, 2);
    add_step(32, 44, rs, a_mtv, 'h34, 0, 0, 0, -1,    0, 0, 38, 2);
    add_step(36,  0, rw, a_msc,    0, 0, 0, 0,  1, 'h34, 0,  0, 2);
    // Fill all eight entries, then one shared wakeup
    add_step(40, 50, rs, a_msc, 'h40, 0, 0, 0, -1, 0, 0, 51, 0);
    add_step(41, 51, rc, a_mst, 'h40, 0, 0, 0, -1, 0, 0, 52, 2);
    add_step(42, 52, rw, a_mep, 'h40, 0, 0, 0, -1, 0, 0, 53, 2);
    add_step(43, 53, rs, a_mca, 'h40, 0, 0, 0, -1, 0, 0, 54, 2);
    add_step(44, 54, rc, a_mtv, 'h40, 0, 0, 0, -1, 0, 0, 55, 2);
    add_step(45, 55, rw, a_msc, 'h40, 0, 0, 0, -1, 0, 0, 56, 2);
    add_step(46, 56, rs, a_mst, 'h40, 0, 0, 0, -1, 0, 0, 57, 0);
    add_step(47, 57, rc, a_mep, 'h40, 0, 0, 0, -1, 0, 0, 58, 1);
    add_step(49,  0, rw, a_msc,    0, 0, 0, 0,  1, 'h40, 0, 0, 1);
    add_step(50,  0, rw, a_msc,    0, 0, 0, 0, -1,    0, 0, 0, 0);
    // Unknown addresses
    add_step(60, 60, rw, 12'h7c0,    0, 0, 1, 'h1f, -1, 0, 0, 62, 2);
    add_step(61, 61, rs, 12'h344, 'h26, 1, 0,    0, -1, 0, 0, 63, 2);
    // Flush with two waiting and 72 in flight
    add_step(66, 70, rw, a_msc, 'h50, 0, 0,    0, -1,    0, 0, 0, 2);
    add_step(67, 71, rw, a_mtv, 'h51, 0, 0,    0, -1,    0, 0, 0, 2);
    add_step(68, 72, rw, a_mep,    0, 0, 1, 'h1c, -1,    0, 0, 0, 2);
    add_step(70,  0, rw, a_msc,    0, 0, 0,    0, -1,    0, 1, 0, 0);
    add_step(71,  0, rw, a_msc,    0, 0, 0,    0,  0, 'h50, 0, 0, 0);
    add_step(72,  0, rw, a_msc,    0, 0, 0,    0,  2, 'h51, 0, 0, 2);
    add_step(75, 75, rs, a_mst, 0, 0, 1, 0, -1, 0, 0, 77, 2);
    add_step(76, 76, rs, a_mtv, 0, 0, 1, 0, -1, 0, 0, 78, 2);
    add_step(77, 77, rs, a_msc, 0, 0, 1, 0, -1, 0, 0, 79, 2);
    add_step(78, 78, rs, a_mep, 0, 0, 1, 0, -1, 0, 0, 80, 2);
    add_step(79, 79, rs, a_mca, 0, 0, 1, 0, -1, 0, 0, 81, 2);
    // Flush with all eight entries waiting
    add_step(82, 82, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 0);
    add_step(83, 83, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 2);
    add_step(84, 84, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 2);
    add_step(85, 85, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 2);
    add_step(86, 86, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 2);
    add_step(87, 87, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 2);
    add_step(88, 88, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 2);
    add_step(89, 89, rw, a_msc, 'h60, 0, 0, 0, -1,    0, 0, 0, 1);
    add_step(90,  0, rw, a_msc,    0, 0, 0, 0, -1,    0, 1, 0, 0);
    add_step(91,  0, rw, a_msc,    0, 0, 0, 0,  0, 'h60, 0, 0, 0);
  endtask

  initial begin
    logic [31:0] lfsr;
    clk            = 1'b0;
    arst_n         = 1'b0;
    flush          = 1'b0;
    disp_valid     = 1'b0;
    disp_inst_num  = '0;
    disp_rd        = '0;
    disp_op        = rw;
    disp_src_tag   = '0;
    disp_src_ready = 1'b0;
    disp_use_imm   = 1'b0;
    disp_zimm      = '0;
    disp_addr      = '0;
    wake_valid     = '0;
    wake_tag       = '0;
    csr_m          = '{32'h0, 32'h100, 32'h0, 32'h0, 32'h0};
    lfsr           = 32'd29;
    for (int t = 0; t < 256; t++) begin
      for (int b = 0; b < 32; b++) begin
        lfsr       = lfsr_next(lfsr);
        prf[t][b]  = lfsr[0];
      end
    end
    build_table();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    for (int c = 1; c <= n_cyc; c++) begin
      @(posedge clk);
      drive_cycle(c);
      @(negedge clk);
      check_edge(c - 1); // Edge c-1 has settled
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #((n_cyc + 8 + 20) * 20);
    $display("Watchdog expired before the stimulus table finished");
    $display("test failed");
    $finish;
  end

endmodule

/* verilog.f */
csr_pkg.sv
csr_issue_if.sv
csr_file.sv
csr_exec.sv
csr_rs.sv
csr_core.sv
tb_csr_core.sv

/* Bender.yml */
package:
  name: csr_core

sources:
  - csr_pkg.sv
  - csr_issue_if.sv
  - csr_file.sv
  - csr_exec.sv
  - csr_rs.sv
  - csr_core.sv
  - target: test
    files:
      - tb_csr_core.sv
